// ==== axi_atop_guard.f ====
+incdir+include
hw/axi_atop_guard_pkg.sv
hw/w_route_fifo.sv
hw/atop_filter.sv
hw/axi_mem_slave.sv
hw/axi_atop_guard_top.sv
verification/tb_axi_atop_guard.sv

// ==== Makefile ====
TOP = tb_axi_atop_guard
FLIST = axi_atop_guard.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Finished with no errors" sim.log; then echo "simulation aborted"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_axi_atop_guard.sv ====
/* atop guard testbench */
`include "axi_atop_guard_macros.svh"

module tb_axi_atop_guard;

  typedef enum logic [1:0] {kind_write, kind_read, kind_atomic} kind_e;

  // one request, the expected answers follow from kind and atop
  typedef struct packed {
    kind_e kind;
    axi_atop_guard_pkg::id_t id;
    axi_atop_guard_pkg::addr_t addr;
    axi_atop_guard_pkg::len_t len;
    axi_atop_guard_pkg::atop_t atop;
    axi_atop_guard_pkg::data_t data;
    logic stall;
  } row_t;

  localparam int num_rows = 16;
  // cycles any single wait may take before the run is given up
  localparam int timeout = 200;

  logic clk_i;
  logic rst_n;
  logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready, r_last;
  axi_atop_guard_pkg::id_t aw_id, b_id, ar_id, r_id;
  axi_atop_guard_pkg::addr_t aw_addr, ar_addr;
  axi_atop_guard_pkg::len_t aw_len, ar_len;
  axi_atop_guard_pkg::atop_t aw_atop;
  axi_atop_guard_pkg::data_t w_data, r_data;
  axi_atop_guard_pkg::strb_t w_strb;
  axi_atop_guard_pkg::resp_t b_resp, r_resp;

  row_t rows [num_rows];
  // mirror of the memory, only plain writes change it
  axi_atop_guard_pkg::data_t model_mem [`MEM_WORDS];
  int errors;
  int rows_failed;
  int rows_run;
  bit timed_out;

  axi_atop_guard_top axi_atop_guard_top_i (
    .clk_i, .rst_n,
    .aw_valid, .aw_ready, .aw_id, .aw_addr, .aw_len, .aw_atop,
    .w_valid, .w_ready, .w_data, .w_strb, .w_last,
    .b_valid, .b_ready, .b_id, .b_resp,
    .ar_valid, .ar_ready, .ar_id, .ar_addr, .ar_len,
    .r_valid, .r_ready, .r_id, .r_data, .r_resp, .r_last
  );

  always #50 clk_i = ~clk_i;

  function automatic row_t make_row(input kind_e kind, input logic [3:0] id,
                                    input logic [7:0] addr, input logic [3:0] len,
                                    input logic [5:0] atop, input logic [31:0] data,
                                    input logic stall);
    return '{kind, id, addr, len, atop, data, stall};
  endfunction

  function automatic string kind_label(input kind_e kind);
    case (kind)
      kind_write: return "write";
      kind_read: return "read";
      default: return "atomic";
    endcase
  endfunction

  // word of beat n, counted from the address bits above the byte offset
  function automatic int word_index(input axi_atop_guard_pkg::addr_t addr, input int beat);
    return (int'(addr) / (`AXI_DATA_WIDTH / 8) + beat) % `MEM_WORDS;
  endfunction

  // every beat of a burst carries a different word
  function automatic axi_atop_guard_pkg::data_t beat_data(input axi_atop_guard_pkg::data_t base,
                                                          input int beat);
    return base + 32'(beat) * 32'h0001_0001;
  endfunction

  task automatic fill_table();
    // first pass without stalls, plain bursts then atomics on the same words
    rows[0] = make_row(kind_write, 4'd1, 8'h00, 4'd3, 6'h00, 32'h1000_0000, 1'b0);
    rows[1] = make_row(kind_read, 4'd2, 8'h00, 4'd3, 6'h00, 32'h0, 1'b0);
    rows[2] = make_row(kind_write, 4'd3, 8'h40, 4'd0, 6'h00, 32'h2000_0000, 1'b0);
    rows[3] = make_row(kind_read, 4'd3, 8'h40, 4'd0, 6'h00, 32'h0, 1'b0);
    rows[4] = make_row(kind_atomic, 4'd5, 8'h00, 4'd1, 6'h11, 32'hdead_0000, 1'b0);
    rows[5] = make_row(kind_read, 4'd6, 8'h00, 4'd3, 6'h00, 32'h0, 1'b0);
    rows[6] = make_row(kind_atomic, 4'd7, 8'h40, 4'd2, 6'h21, 32'hbeef_0000, 1'b0);
    rows[7] = make_row(kind_read, 4'd8, 8'h40, 4'd0, 6'h00, 32'h0, 1'b0);
    // second pass mixes everything with random b_ready and r_ready
    rows[8] = make_row(kind_write, 4'd9, 8'h80, 4'd7, 6'h00, 32'h3000_0000, 1'b1);
    rows[9] = make_row(kind_atomic, 4'd10, 8'h80, 4'd3, 6'h31, 32'hcafe_0000, 1'b1);
    rows[10] = make_row(kind_read, 4'd11, 8'h80, 4'd7, 6'h00, 32'h0, 1'b1);
    rows[11] = make_row(kind_atomic, 4'd12, 8'h84, 4'd0, 6'h12, 32'hf00d_0000, 1'b1);
    rows[12] = make_row(kind_write, 4'd13, 8'hf0, 4'd3, 6'h00, 32'h4000_0000, 1'b1);
    rows[13] = make_row(kind_read, 4'd14, 8'hf0, 4'd3, 6'h00, 32'h0, 1'b1);
    rows[14] = make_row(kind_atomic, 4'd15, 8'hf0, 4'd1, 6'h20, 32'hface_0000, 1'b1);
    rows[15] = make_row(kind_read, 4'd15, 8'hf0, 4'd3, 6'h00, 32'h0, 1'b1);
  endtask

  task automatic compare_signal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_timeout(input int row, input string what);
    $display("timeout at %0t: row %0d waited too long for %s", $time, row, what);
    errors++;
    timed_out = 1'b1;
  endtask

  // inputs change a little after the rising edge, outputs are read at the falling one
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic send_aw(input int row, input row_t r);
    int waited;
    bit done;
    waited = 0;
    done = 1'b0;
    aw_valid = 1'b1;
    aw_id = r.id;
    aw_addr = r.addr;
    aw_len = r.len;
    aw_atop = r.atop;
    while (!done && !timed_out) begin
      @(negedge clk_i);
      if (aw_ready) begin
        done = 1'b1;
      end else begin
        waited++;
        if (waited >= timeout) begin
          report_timeout(row, "aw_ready");
        end
      end
      next_cycle();
    end
    aw_valid = 1'b0;
  endtask

  task automatic send_ar(input int row, input row_t r);
    int waited;
    bit done;
    waited = 0;
    done = 1'b0;
    ar_valid = 1'b1;
    ar_id = r.id;
    ar_addr = r.addr;
    ar_len = r.len;
    while (!done && !timed_out) begin
      @(negedge clk_i);
      if (ar_ready) begin
        done = 1'b1;
      end else begin
        waited++;
        if (waited >= timeout) begin
          report_timeout(row, "ar_ready");
        end
      end
      next_cycle();
    end
    ar_valid = 1'b0;
  endtask

  task automatic send_w(input int row, input row_t r);
    int waited;
    int beat;
    waited = 0;
    beat = 0;
    w_strb = '1;
    while (beat <= int'(r.len) && !timed_out) begin
      w_valid = 1'b1;
      w_data = beat_data(r.data, beat);
      w_last = (beat == int'(r.len));
      @(negedge clk_i);
      if (w_ready) begin
        beat++;
        waited = 0;
      end else begin
        waited++;
        if (waited >= timeout) begin
          report_timeout(row, "w_ready");
        end
      end
      next_cycle();
    end
    w_valid = 1'b0;
    w_last = 1'b0;
  endtask

  // no r beat may show up before the b response of a write
  task automatic wait_b(input int row, input row_t r, input axi_atop_guard_pkg::resp_t resp);
    int waited;
    bit done;
    waited = 0;
    done = 1'b0;
    while (!done && !timed_out) begin
      b_ready = r.stall ? (($urandom % 3) != 0) : 1'b1;
      @(negedge clk_i);
      compare_signal("r_valid", 32'(1'b0), 32'(r_valid));
      if (b_valid && b_ready) begin
        compare_signal("b_id", 32'(r.id), 32'(b_id));
        compare_signal("b_resp", 32'(resp), 32'(b_resp));
        done = 1'b1;
      end else begin
        waited++;
        if (waited >= timeout) begin
          report_timeout(row, "b_valid");
        end
      end
      next_cycle();
    end
    b_ready = 1'b0;
  endtask

  task automatic collect_r(input int row, input row_t r, input axi_atop_guard_pkg::resp_t resp,
                           input bit check_data);
    int waited;
    int beat;
    waited = 0;
    beat = 0;
    while (beat <= int'(r.len) && !timed_out) begin
      r_ready = r.stall ? (($urandom % 3) != 0) : 1'b1;
      @(negedge clk_i);
      if (r_valid && r_ready) begin
        compare_signal("r_id", 32'(r.id), 32'(r_id));
        compare_signal("r_resp", 32'(resp), 32'(r_resp));
        compare_signal("r_last", 32'(beat == int'(r.len)), 32'(r_last));
        if (check_data) begin
          compare_signal("r_data", model_mem[word_index(r.addr, beat)], r_data);
        end
        beat++;
        waited = 0;
      end else begin
        waited++;
        if (waited >= timeout) begin
          report_timeout(row, "r_valid");
        end
      end
      next_cycle();
    end
    r_ready = 1'b0;
  endtask

  // with nothing requested both response channels must stay silent
  task automatic check_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk_i);
      compare_signal("b_valid", 32'(1'b0), 32'(b_valid));
      compare_signal("r_valid", 32'(1'b0), 32'(r_valid));
      next_cycle();
    end
  endtask

  task automatic run_row(input int n, input row_t r);
    int errs_before;
    errs_before = errors;
    case (r.kind)
      kind_write: begin
        send_aw(n, r);
        send_w(n, r);
        wait_b(n, r, axi_atop_guard_pkg::resp_okay);
        for (int beat = 0; beat <= int'(r.len); beat++) begin
          model_mem[word_index(r.addr, beat)] = beat_data(r.data, beat);
        end
      end
      kind_atomic: begin
        send_aw(n, r);
        send_w(n, r);
        wait_b(n, r, axi_atop_guard_pkg::resp_slverr);
        // atop bit 5 asks for len+1 beats of read data as well
        if (r.atop[5]) begin
          collect_r(n, r, axi_atop_guard_pkg::resp_slverr, 1'b0);
        end
      end
      default: begin
        send_ar(n, r);
        collect_r(n, r, axi_atop_guard_pkg::resp_okay, 1'b1);
      end
    endcase
    if (!timed_out) begin
      check_quiet(2);
    end
    if (errors != errs_before) begin
      rows_failed++;
    end
    $display("row %0d %s id %0d len %0d: %s", n, kind_label(r.kind), r.id, r.len,
             (errors == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    void'($urandom(93));
    clk_i = 1'b0;
    rst_n = 1'b0;
    aw_valid = 1'b0;
    aw_id = '0;
    aw_addr = '0;
    aw_len = '0;
    aw_atop = '0;
    w_valid = 1'b0;
    w_data = '0;
    w_strb = '0;
    w_last = 1'b0;
    b_ready = 1'b0;
    ar_valid = 1'b0;
    ar_id = '0;
    ar_addr = '0;
    ar_len = '0;
    r_ready = 1'b0;
    errors = 0;
    rows_failed = 0;
    rows_run = 0;
    timed_out = 1'b0;
    fill_table();
    repeat (2) @(posedge clk_i);
    #10;
    rst_n = 1'b1;
    check_quiet(4);
    for (int n = 0; n < num_rows && !timed_out; n++) begin
      run_row(n, rows[n]);
      rows_run++;
    end
    $display("%0d rows run, %0d rows failed, %0d checks failed", rows_run, rows_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== hw/axi_atop_guard_top.sv ====
/* atop guard subsystem */

module axi_atop_guard_top (
  input  logic clk_i,
  input  logic rst_n,
  input  logic aw_valid,
  output logic aw_ready,
  input  axi_atop_guard_pkg::id_t aw_id,
  input  axi_atop_guard_pkg::addr_t aw_addr,
  input  axi_atop_guard_pkg::len_t aw_len,
  input  axi_atop_guard_pkg::atop_t aw_atop,
  input  logic w_valid,
  output logic w_ready,
  input  axi_atop_guard_pkg::data_t w_data,
  input  axi_atop_guard_pkg::strb_t w_strb,
  input  logic w_last,
  output logic b_valid,
  input  logic b_ready,
  output axi_atop_guard_pkg::id_t b_id,
  output axi_atop_guard_pkg::resp_t b_resp,
  input  logic ar_valid,
  output logic ar_ready,
  input  axi_atop_guard_pkg::id_t ar_id,
  input  axi_atop_guard_pkg::addr_t ar_addr,
  input  axi_atop_guard_pkg::len_t ar_len,
  output logic r_valid,
  input  logic r_ready,
  output axi_atop_guard_pkg::id_t r_id,
  output axi_atop_guard_pkg::data_t r_data,
  output axi_atop_guard_pkg::resp_t r_resp,
  output logic r_last
);

  // filtered channel set between the filter and the memory
  logic mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready, mem_w_last;
  logic mem_b_valid, mem_b_ready, mem_ar_valid, mem_ar_ready;
  logic mem_r_valid, mem_r_ready, mem_r_last;
  axi_atop_guard_pkg::id_t mem_aw_id, mem_b_id, mem_ar_id, mem_r_id;
  axi_atop_guard_pkg::addr_t mem_aw_addr, mem_ar_addr;
  axi_atop_guard_pkg::len_t mem_aw_len, mem_ar_len;
  axi_atop_guard_pkg::data_t mem_w_data, mem_r_data;
  axi_atop_guard_pkg::strb_t mem_w_strb;
  axi_atop_guard_pkg::resp_t mem_b_resp, mem_r_resp;
  // routing tags between the filter and its FIFO
  logic route_push, route_tag, route_pop, route_head, route_full, route_empty;

  atop_filter i_atop_filter (
    .clk_i, .rst_n,
    .aw_valid, .aw_ready, .aw_id, .aw_addr, .aw_len, .aw_atop,
    .w_valid, .w_ready, .w_data, .w_strb, .w_last,
    .b_valid, .b_ready, .b_id, .b_resp,
    .ar_valid, .ar_ready, .ar_id, .ar_addr, .ar_len,
    .r_valid, .r_ready, .r_id, .r_data, .r_resp, .r_last,
    .mem_aw_valid, .mem_aw_ready, .mem_aw_id, .mem_aw_addr, .mem_aw_len,
    .mem_w_valid, .mem_w_ready, .mem_w_data, .mem_w_strb, .mem_w_last,
    .mem_b_valid, .mem_b_ready, .mem_b_id, .mem_b_resp,
    .mem_ar_valid, .mem_ar_ready, .mem_ar_id, .mem_ar_addr, .mem_ar_len,
    .mem_r_valid, .mem_r_ready, .mem_r_id, .mem_r_data, .mem_r_resp, .mem_r_last,
    .route_push, .route_tag, .route_pop, .route_head, .route_full, .route_empty
  );

  w_route_fifo i_w_route_fifo (
    .clk_i, .rst_n,
    .push(route_push), .push_tag(route_tag), .pop(route_pop),
    .head_tag(route_head), .full(route_full), .empty(route_empty)
  );

  // the memory sees the filtered set on its plain slave ports
  axi_mem_slave i_axi_mem_slave (
    .clk_i, .rst_n,
    .aw_valid(mem_aw_valid), .aw_ready(mem_aw_ready), .aw_id(mem_aw_id),
    .aw_addr(mem_aw_addr), .aw_len(mem_aw_len),
    .w_valid(mem_w_valid), .w_ready(mem_w_ready), .w_data(mem_w_data),
    .w_strb(mem_w_strb), .w_last(mem_w_last),
    .b_valid(mem_b_valid), .b_ready(mem_b_ready), .b_id(mem_b_id), .b_resp(mem_b_resp),
    .ar_valid(mem_ar_valid), .ar_ready(mem_ar_ready), .ar_id(mem_ar_id),
    .ar_addr(mem_ar_addr), .ar_len(mem_ar_len),
    .r_valid(mem_r_valid), .r_ready(mem_r_ready), .r_id(mem_r_id),
    .r_data(mem_r_data), .r_resp(mem_r_resp), .r_last(mem_r_last)
  );

endmodule

// ==== hw/axi_mem_slave.sv ====
/* AXI memory slave */
`include "axi_atop_guard_macros.svh"

module axi_mem_slave (
  input  logic clk_i,
  input  logic rst_n,
  input  logic aw_valid,
  output logic aw_ready,
  input  axi_atop_guard_pkg::id_t aw_id,
  input  axi_atop_guard_pkg::addr_t aw_addr,
  input  axi_atop_guard_pkg::len_t aw_len,
  input  logic w_valid,
  output logic w_ready,
  input  axi_atop_guard_pkg::data_t w_data,
  input  axi_atop_guard_pkg::strb_t w_strb,
  input  logic w_last,
  output logic b_valid,
  input  logic b_ready,
  output axi_atop_guard_pkg::id_t b_id,
  output axi_atop_guard_pkg::resp_t b_resp,
  input  logic ar_valid,
  output logic ar_ready,
  input  axi_atop_guard_pkg::id_t ar_id,
  input  axi_atop_guard_pkg::addr_t ar_addr,
  input  axi_atop_guard_pkg::len_t ar_len,
  output logic r_valid,
  input  logic r_ready,
  output axi_atop_guard_pkg::id_t r_id,
  output axi_atop_guard_pkg::data_t r_data,
  output axi_atop_guard_pkg::resp_t r_resp,
  output logic r_last
);

  // byte offset bits are dropped, the next bits pick the word
  localparam int strb_w = `AXI_DATA_WIDTH / 8;
  localparam int off_w = $clog2(strb_w);
  localparam int idx_w = $clog2(`MEM_WORDS);

  axi_atop_guard_pkg::data_t mem [`MEM_WORDS];
  axi_atop_guard_pkg::mem_state_e state;
  // the burst in progress, only one at a time in either direction
  axi_atop_guard_pkg::id_t burst_id;
  axi_atop_guard_pkg::len_t burst_len;
  axi_atop_guard_pkg::len_t beat;
  logic [idx_w-1:0] idx;
  logic aw_hs;
  logic ar_hs;
  logic w_hs;
  logic r_hs;

  assign aw_ready = (state == axi_atop_guard_pkg::mem_idle);
  // a read only starts when no write is waiting
  assign ar_ready = (state == axi_atop_guard_pkg::mem_idle) && !aw_valid;
  assign w_ready = (state == axi_atop_guard_pkg::mem_write);
  assign aw_hs = aw_valid && aw_ready;
  assign ar_hs = ar_valid && ar_ready;
  assign w_hs = w_valid && w_ready;
  assign r_hs = r_valid && r_ready;

  assign b_valid = (state == axi_atop_guard_pkg::mem_write_resp);
  assign b_id = burst_id;
  assign b_resp = axi_atop_guard_pkg::resp_okay;

  assign r_valid = (state == axi_atop_guard_pkg::mem_read);
  assign r_id = burst_id;
  assign r_data = mem[idx];
  assign r_resp = axi_atop_guard_pkg::resp_okay;
  assign r_last = (beat == burst_len);

  // each strobed byte lands in the word the burst currently points at
  always_ff @(posedge clk_i) begin
    if (w_hs) begin
      for (int i = 0; i < strb_w; i++) begin
        if (w_strb[i]) begin
          mem[idx][8*i +: 8] <= w_data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      burst_id <= aw_id;
      burst_len <= aw_len;
      idx <= aw_addr[off_w +: idx_w];
    end else if (ar_hs) begin
      burst_id <= ar_id;
      burst_len <= ar_len;
      idx <= ar_addr[off_w +: idx_w];
    end else if (w_hs || r_hs) begin
      // incr bursts step one word per beat
      idx <= idx + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state <= axi_atop_guard_pkg::mem_idle;
      beat <= '0;
    end else begin
      case (state)
        axi_atop_guard_pkg::mem_idle: begin
          beat <= '0;
          if (aw_hs) begin
            state <= axi_atop_guard_pkg::mem_write;
          end else if (ar_hs) begin
            state <= axi_atop_guard_pkg::mem_read;
          end
        end
        axi_atop_guard_pkg::mem_write: begin
          if (w_hs) begin
            beat <= beat + 1'b1;
            if (w_last) begin
              state <= axi_atop_guard_pkg::mem_write_resp;
            end
          end
        end
        axi_atop_guard_pkg::mem_write_resp: begin
          if (b_ready) begin
            state <= axi_atop_guard_pkg::mem_idle;
          end
        end
        axi_atop_guard_pkg::mem_read: begin
          if (r_hs) begin
            beat <= beat + 1'b1;
            if (r_last) begin
              state <= axi_atop_guard_pkg::mem_idle;
            end
          end
        end
        default: state <= axi_atop_guard_pkg::mem_idle;
      endcase
    end
  end

  // the manager closes every write burst exactly on beat len+1
  assert property (@(posedge clk_i) disable iff (!rst_n)
    w_hs |-> (w_last == (beat == burst_len)));

endmodule

// ==== hw/atop_filter.sv ====
/* atomic operation filter */

module atop_filter (
  input  logic clk_i,
  input  logic rst_n,
  // slave side, towards the upstream manager
  input  logic aw_valid,
  output logic aw_ready,
  input  axi_atop_guard_pkg::id_t aw_id,
  input  axi_atop_guard_pkg::addr_t aw_addr,
  input  axi_atop_guard_pkg::len_t aw_len,
  input  axi_atop_guard_pkg::atop_t aw_atop,
  input  logic w_valid,
  output logic w_ready,
  input  axi_atop_guard_pkg::data_t w_data,
  input  axi_atop_guard_pkg::strb_t w_strb,
  input  logic w_last,
  output logic b_valid,
  input  logic b_ready,
  output axi_atop_guard_pkg::id_t b_id,
  output axi_atop_guard_pkg::resp_t b_resp,
  input  logic ar_valid,
  output logic ar_ready,
  input  axi_atop_guard_pkg::id_t ar_id,
  input  axi_atop_guard_pkg::addr_t ar_addr,
  input  axi_atop_guard_pkg::len_t ar_len,
  output logic r_valid,
  input  logic r_ready,
  output axi_atop_guard_pkg::id_t r_id,
  output axi_atop_guard_pkg::data_t r_data,
  output axi_atop_guard_pkg::resp_t r_resp,
  output logic r_last,
  // memory side, never carries an atomic
  output logic mem_aw_valid,
  input  logic mem_aw_ready,
  output axi_atop_guard_pkg::id_t mem_aw_id,
  output axi_atop_guard_pkg::addr_t mem_aw_addr,
  output axi_atop_guard_pkg::len_t mem_aw_len,
  output logic mem_w_valid,
  input  logic mem_w_ready,
  output axi_atop_guard_pkg::data_t mem_w_data,
  output axi_atop_guard_pkg::strb_t mem_w_strb,
  output logic mem_w_last,
  input  logic mem_b_valid,
  output logic mem_b_ready,
  input  axi_atop_guard_pkg::id_t mem_b_id,
  input  axi_atop_guard_pkg::resp_t mem_b_resp,
  output logic mem_ar_valid,
  input  logic mem_ar_ready,
  output axi_atop_guard_pkg::id_t mem_ar_id,
  output axi_atop_guard_pkg::addr_t mem_ar_addr,
  output axi_atop_guard_pkg::len_t mem_ar_len,
  input  logic mem_r_valid,
  output logic mem_r_ready,
  input  axi_atop_guard_pkg::id_t mem_r_id,
  input  axi_atop_guard_pkg::data_t mem_r_data,
  input  axi_atop_guard_pkg::resp_t mem_r_resp,
  input  logic mem_r_last,
  // w routing FIFO
  output logic route_push,
  output logic route_tag,
  output logic route_pop,
  input  logic route_head,
  input  logic route_full,
  input  logic route_empty
);

  axi_atop_guard_pkg::filter_state_e state;
  // the atomic being answered, latched when its aw is taken
  axi_atop_guard_pkg::id_t atop_id;
  axi_atop_guard_pkg::len_t atop_len;
  logic atop_ret_r;
  axi_atop_guard_pkg::len_t r_cnt;
  logic is_atop;
  logic atop_aw_hs;
  logic w_fwd;
  logic w_absorb;
  logic b_hold;
  logic b_hold_inj;
  logic b_pick_inj;
  logic inj_b_hs;
  logic r_busy;
  logic r_busy_inj;
  logic r_pick_inj;
  logic inj_r_hs;

  // plain writes go straight through, atomics wait for an idle FSM
  assign is_atop = (aw_atop != '0);
  assign mem_aw_valid = aw_valid && !is_atop && !route_full;
  assign mem_aw_id = aw_id;
  assign mem_aw_addr = aw_addr;
  assign mem_aw_len = aw_len;
  assign aw_ready = !route_full &&
                    (is_atop ? (state == axi_atop_guard_pkg::idle) : mem_aw_ready);
  assign route_push = aw_valid && aw_ready;
  assign route_tag = is_atop;
  assign atop_aw_hs = route_push && is_atop;

  // the head tag decides where the current w burst goes
  assign w_fwd = !route_empty && !route_head;
  assign w_absorb = !route_empty && route_head && (state == axi_atop_guard_pkg::absorb);
  assign mem_w_valid = w_valid && w_fwd;
  assign mem_w_data = w_data;
  assign mem_w_strb = w_strb;
  assign mem_w_last = w_last;
  assign w_ready = w_fwd ? mem_w_ready : w_absorb;
  assign route_pop = w_valid && w_ready && w_last;

  // reads are never atomic and pass unchanged
  assign mem_ar_valid = ar_valid;
  assign ar_ready = mem_ar_ready;
  assign mem_ar_id = ar_id;
  assign mem_ar_addr = ar_addr;
  assign mem_ar_len = ar_len;

  // b mux, a presented response keeps its source until the handshake
  assign b_pick_inj = b_hold ? b_hold_inj : (state == axi_atop_guard_pkg::send_b);
  assign b_valid = b_pick_inj ? 1'b1 : mem_b_valid;
  assign b_id = b_pick_inj ? atop_id : mem_b_id;
  assign b_resp = b_pick_inj ? axi_atop_guard_pkg::resp_slverr : mem_b_resp;
  assign mem_b_ready = !b_pick_inj && b_ready;
  assign inj_b_hs = b_pick_inj && b_ready;

  // r mux, locked to one source from the first beat up to r_last
  assign r_pick_inj = r_busy ? r_busy_inj : (state == axi_atop_guard_pkg::send_r);
  assign r_valid = r_pick_inj ? 1'b1 : mem_r_valid;
  assign r_id = r_pick_inj ? atop_id : mem_r_id;
  assign r_data = r_pick_inj ? '0 : mem_r_data;
  assign r_resp = r_pick_inj ? axi_atop_guard_pkg::resp_slverr : mem_r_resp;
  assign r_last = r_pick_inj ? (r_cnt == atop_len) : mem_r_last;
  assign mem_r_ready = !r_pick_inj && r_ready;
  assign inj_r_hs = r_pick_inj && r_ready;

  always_ff @(posedge clk_i) begin
    if (atop_aw_hs) begin
      atop_id <= aw_id;
      atop_len <= aw_len;
      // bit 5 marks the atomics that also return read data
      atop_ret_r <= aw_atop[5];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state <= axi_atop_guard_pkg::idle;
      r_cnt <= '0;
    end else begin
      case (state)
        axi_atop_guard_pkg::idle: begin
          if (atop_aw_hs) begin
            state <= axi_atop_guard_pkg::absorb;
          end
        end
        axi_atop_guard_pkg::absorb: begin
          if (w_valid && w_absorb && w_last) begin
            state <= axi_atop_guard_pkg::send_b;
          end
        end
        axi_atop_guard_pkg::send_b: begin
          if (inj_b_hs) begin
            r_cnt <= '0;
            state <= atop_ret_r ? axi_atop_guard_pkg::send_r : axi_atop_guard_pkg::idle;
          end
        end
        axi_atop_guard_pkg::send_r: begin
          if (inj_r_hs) begin
            if (r_cnt == atop_len) begin
              state <= axi_atop_guard_pkg::idle;
            end else begin
              r_cnt <= r_cnt + 1'b1;
            end
          end
        end
        default: state <= axi_atop_guard_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      b_hold <= 1'b0;
      b_hold_inj <= 1'b0;
      r_busy <= 1'b0;
      r_busy_inj <= 1'b0;
    end else begin
      if (b_valid) begin
        b_hold <= !b_ready;
        b_hold_inj <= b_pick_inj;
      end
      // a stalled beat or a burst that has not reached r_last keeps the lock
      if (r_valid) begin
        r_busy <= !(r_ready && r_last);
        r_busy_inj <= r_pick_inj;
      end
    end
  end

  // a write taken by the memory leaves its routing entry queued in the FIFO
  assert property (@(posedge clk_i) disable iff (!rst_n)
    (mem_aw_valid && mem_aw_ready) |=> !route_empty);
  // the memory only waits for w beats while their routing entry is queued
  assert property (@(posedge clk_i) disable iff (!rst_n) mem_w_ready |-> !route_empty);
  // the last injected beat frees both the FSM and the r lock
  assert property (@(posedge clk_i) disable iff (!rst_n)
    (inj_r_hs && r_last) |=> (state == axi_atop_guard_pkg::idle && !r_busy));

endmodule

// ==== hw/w_route_fifo.sv ====
/* w routing tag FIFO */
`include "axi_atop_guard_macros.svh"

module w_route_fifo (
  input  logic clk_i,
  input  logic rst_n,
  input  logic push,
  input  logic push_tag,
  input  logic pop,
  output logic head_tag,
  output logic full,
  output logic empty
);

  // one entry for every write burst whose w beats are still due
  localparam int depth = `AXI_MAX_WRITE_TXNS;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam logic [ptr_w:0] depth_cnt = (ptr_w + 1)'(depth);
  localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);

  logic tags [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0] count;

  // a tag of one means the burst is an atomic and its beats are dropped
  assign head_tag = tags[rd_ptr];
  assign full = (count == depth_cnt);
  assign empty = (count == '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      tags[wr_ptr] <= push_tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      // pointers wrap explicitly so the depth need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the filter must hold aw back while every slot is taken
  assert property (@(posedge clk_i) disable iff (!rst_n) !(push && full));
  // a last w beat never shows up before its aw was accepted
  assert property (@(posedge clk_i) disable iff (!rst_n) !(pop && empty));

endmodule

// ==== hw/axi_atop_guard_pkg.sv ====
/* atop guard types */
`include "axi_atop_guard_macros.svh"

package axi_atop_guard_pkg;

  // transaction id carried on aw, b, ar and r
  typedef logic [`AXI_ID_WIDTH-1:0] id_t;
  // byte address, the low bits select a byte within the word
  typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
  // one strobe bit per data byte
  typedef logic [`AXI_DATA_WIDTH/8-1:0] strb_t;
  // burst length minus one, so a value of zero is a single beat
  typedef logic [3:0] len_t;
  // atomic code, zero is a plain write and bit 5 asks for r data
  typedef logic [5:0] atop_t;
  typedef logic [1:0] resp_t;

  // the only two response codes this subsystem produces
  localparam resp_t resp_okay = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // atomic answer FSM of the filter
  typedef enum logic [1:0] {idle, absorb, send_b, send_r} filter_state_e;

  // combined write and read FSM of the memory
  typedef enum logic [1:0] {mem_idle, mem_write, mem_write_resp, mem_read} mem_state_e;

endpackage

// ==== include/axi_atop_guard_macros.svh ====
/* atop guard parameters */
`ifndef AXI_ATOP_GUARD_MACROS_SVH
`define AXI_ATOP_GUARD_MACROS_SVH

// width of transaction ids on every channel
`define AXI_ID_WIDTH 4

// byte address width, which covers the whole memory
`define AXI_ADDR_WIDTH 8

// data bus width, one word per beat
`define AXI_DATA_WIDTH 32

// write bursts that may be in flight between aw and the last w beat
`define AXI_MAX_WRITE_TXNS 4

// memory depth in data words
`define MEM_WORDS 64

`endif
